// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_spi_gpio
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) rtl/spi_gpio_settings.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+rtl
rtl/spi_regmap_pkg.sv
rtl/spi_xfer_pkg.sv
rtl/spi_gpio_regs.sv
rtl/spi_xfer_engine.sv
rtl/spi_gpio_pinmux.sv
rtl/spi_gpio_top.sv
test/tb_spi_gpio.sv

// File: rtl/spi_gpio_pinmux.sv
`timescale 1ns/1ps
`include "spi_gpio_settings.svh"

module spi_gpio_pinmux (
  input  logic                           ctrlport_clk,
  input  logic                           ctrlport_rst,
  input  spi_regmap_pkg::slave_map_tbl_t map_tbl_i,
  input  spi_xfer_pkg::spi_pins_t        pins_i,
  output logic                           miso_o,
  input  logic [`SPI_GPIO_W-1:0]         gpio_in_i,
  output logic [`SPI_GPIO_W-1:0]         gpio_out_o,
  output logic [`SPI_GPIO_W-1:0]         gpio_ddr_o
);

  import spi_regmap_pkg::*;

  localparam gpio_idx_t UNMAPPED = gpio_idx_t'(`SPI_UNMAPPED);

  logic [`SPI_GPIO_W-1:0] is_sclk;
  logic [`SPI_GPIO_W-1:0] is_mosi;
  logic [`SPI_GPIO_W-1:0] is_cs;
  logic [`SPI_GPIO_W-1:0] cs_val;
  logic [`SPI_GPIO_W-1:0] out_d;

  // --------------------------------------------------
  // line roles
  // --------------------------------------------------

  // descending loop, so slave 0 wins a shared cs line
  always_comb begin
    is_sclk = '0;
    is_mosi = '0;
    is_cs   = '0;
    cs_val  = '0;
    for (int s = `SPI_NUM_SLAVES - 1; s >= 0; s--) begin
      if (map_tbl_i[s].sclk != UNMAPPED) begin
        is_sclk[map_tbl_i[s].sclk] = 1'b1;
      end
      if (map_tbl_i[s].mosi != UNMAPPED) begin
        is_mosi[map_tbl_i[s].mosi] = 1'b1;
      end
      if (map_tbl_i[s].cs != UNMAPPED) begin
        is_cs[map_tbl_i[s].cs]  = 1'b1;
        cs_val[map_tbl_i[s].cs] = pins_i.cs_n[s];
      end
    end
  end

  // sclk over mosi over cs, idle lines low
  assign out_d = (is_sclk & {`SPI_GPIO_W{pins_i.sclk}}) |
                 (~is_sclk & is_mosi & {`SPI_GPIO_W{pins_i.mosi}}) |
                 (~is_sclk & ~is_mosi & cs_val);

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      gpio_out_o <= '0;
      gpio_ddr_o <= '0;
    end else begin
      gpio_out_o <= out_d;
      gpio_ddr_o <= is_sclk | is_mosi | is_cs;
    end
  end

  // miso from whichever slave has cs low
  always_comb begin
    miso_o = 1'b0;
    for (int s = `SPI_NUM_SLAVES - 1; s >= 0; s--) begin
      if (!pins_i.cs_n[s] && (map_tbl_i[s].miso != UNMAPPED)) begin
        miso_o = gpio_in_i[map_tbl_i[s].miso];
      end
    end
  end

endmodule

// File: rtl/spi_gpio_regs.sv
`timescale 1ns/1ps
`include "spi_gpio_settings.svh"

module spi_gpio_regs (
  input  logic                           ctrlport_clk,
  input  logic                           ctrlport_rst,
  input  spi_regmap_pkg::ctrl_req_t      ctrl_req_i,
  output spi_regmap_pkg::ctrl_resp_t     ctrl_resp_o,
  output spi_xfer_pkg::spi_xfer_req_t    xfer_req_o,
  input  spi_xfer_pkg::spi_xfer_rsp_t    xfer_rsp_i,
  output spi_regmap_pkg::slave_map_tbl_t map_tbl_o
);

  import spi_regmap_pkg::*;

  localparam gpio_idx_t UNMAPPED = gpio_idx_t'(`SPI_UNMAPPED);

  // unmapped lines keep the gpio port quiet after reset
  localparam slave_cfg_t SLAVE_CFG_RST = '{
    mosi_edge: 1'b0,
    miso_edge: 1'b0,
    length:    spi_len_t'(0),
    map:       '{cs: UNMAPPED, miso: UNMAPPED, mosi: UNMAPPED, sclk: UNMAPPED}
  };

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------

  ctrl_addr_t req_ofs;
  ctrl_addr_t slave_ofs;
  slave_sel_t slave_idx;
  logic       req_any;
  logic       in_window;
  logic       hit_slave;
  logic       hit_cfg;
  logic       hit_go;
  logic       hit_status;
  logic       hit_info;

  assign req_ofs    = ctrl_req_i.addr - `SPI_BASE_ADDR;
  assign slave_ofs  = req_ofs - `SPI_OFS_SLAVE0;
  assign req_any    = ctrl_req_i.wr | ctrl_req_i.rd;
  // outside the window nobody answers
  assign in_window  = (req_ofs < `SPI_WINDOW);
  // word-aligned setup registers, one per slave
  assign hit_slave  = (slave_ofs < ctrl_addr_t'(4 * `SPI_NUM_SLAVES)) &&
                      (slave_ofs[1:0] == 2'b00);
  assign slave_idx  = slave_ofs[3:2];
  assign hit_cfg    = (req_ofs == `SPI_OFS_XFER_CFG);
  assign hit_go     = (req_ofs == `SPI_OFS_GO);
  assign hit_status = (req_ofs == `SPI_OFS_STATUS);
  assign hit_info   = (req_ofs == `SPI_OFS_INFO);

  // --------------------------------------------------
  // register storage and response
  // --------------------------------------------------

  slave_cfg_t slave_cfg [`SPI_NUM_SLAVES];
  xfer_cfg_t  xfer_cfg;
  logic       ready_q;
  logic       go_accept;

  // go while busy is acked but dropped
  assign go_accept = ctrl_req_i.wr && hit_go && ready_q;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      ctrl_resp_o.ack  <= 1'b0;
      xfer_req_o.start <= 1'b0;
      ready_q          <= 1'b1;
      xfer_cfg         <= '0;
      for (int s = 0; s < `SPI_NUM_SLAVES; s++) begin
        slave_cfg[s] <= SLAVE_CFG_RST;
      end
    end else begin
      ctrl_resp_o.ack  <= 1'b0;
      xfer_req_o.start <= go_accept;

      // engine done sets ready, start clears it
      if (xfer_rsp_i.done) begin
        ready_q <= 1'b1;
      end
      if (go_accept) begin
        ready_q <= 1'b0;
      end

      if (req_any && in_window) begin
        ctrl_resp_o.ack    <= 1'b1;
        ctrl_resp_o.status <= OKAY;
        ctrl_resp_o.data   <= '0;
        if (ctrl_req_i.wr) begin
          if (hit_slave) begin
            slave_cfg[slave_idx] <= slave_cfg_t'(ctrl_req_i.data[$bits(slave_cfg_t)-1:0]);
          end else if (hit_cfg) begin
            xfer_cfg <= xfer_cfg_t'(ctrl_req_i.data[$bits(xfer_cfg_t)-1:0]);
          end else if (!hit_go) begin
            // status, info and gaps are read only or empty
            ctrl_resp_o.status <= CMDERR;
          end
        end else begin
          if (hit_cfg) begin
            ctrl_resp_o.data <= ctrl_data_t'(xfer_cfg);
          end else if (hit_status) begin
            // ready lands in bit 24 above rx
            ctrl_resp_o.data <= ctrl_data_t'({ready_q, xfer_rsp_i.rx});
          end else if (hit_info) begin
            ctrl_resp_o.data <= ctrl_data_t'(4'(`SPI_NUM_SLAVES));
          end else begin
            ctrl_resp_o.status <= CMDERR;
          end
        end
      end

      // selected slave setup frozen for the whole transfer
      if (go_accept) begin
        xfer_req_o.data      <= ctrl_req_i.data;
        xfer_req_o.length    <= slave_cfg[xfer_cfg.slave].length;
        xfer_req_o.miso_edge <= slave_cfg[xfer_cfg.slave].miso_edge;
        xfer_req_o.mosi_edge <= slave_cfg[xfer_cfg.slave].mosi_edge;
        xfer_req_o.slave     <= xfer_cfg.slave;
        xfer_req_o.divider   <= xfer_cfg.divider;
      end
    end
  end

  // pin mapping straight from the setup registers
  always_comb begin
    for (int s = 0; s < `SPI_NUM_SLAVES; s++) begin
      map_tbl_o[s] = slave_cfg[s].map;
    end
  end

  // single-cycle requests give isolated acks
  a_ack_single : assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    ctrl_resp_o.ack |=> !ctrl_resp_o.ack);

endmodule

// File: rtl/spi_gpio_settings.svh
`ifndef SPI_GPIO_SETTINGS_SVH
`define SPI_GPIO_SETTINGS_SVH

// number of spi slaves, fixed
`define SPI_NUM_SLAVES 4

// ctrlport window of the block
`define SPI_BASE_ADDR 20'h00000
`define SPI_WINDOW 20'h00020

// register offsets inside the window
`define SPI_OFS_SLAVE0 20'h00000
`define SPI_OFS_XFER_CFG 20'h00010
`define SPI_OFS_GO 20'h00014
`define SPI_OFS_STATUS 20'h00018
`define SPI_OFS_INFO 20'h0001C

// bus and field widths
`define SPI_ADDR_W 20
`define SPI_DATA_W 32
`define SPI_RX_W 24
`define SPI_LEN_W 6
`define SPI_DIV_W 16
`define SPI_IDX_W 5
`define SPI_SEL_W 2

// gpio port, line 31 doubles as "not mapped"
`define SPI_GPIO_W 32
`define SPI_UNMAPPED 31

`endif

// File: rtl/spi_gpio_top.sv
`timescale 1ns/1ps
`include "spi_gpio_settings.svh"

module spi_gpio_top (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  input  spi_regmap_pkg::ctrl_req_t  ctrl_req_i,
  output spi_regmap_pkg::ctrl_resp_t ctrl_resp_o,
  input  logic [`SPI_GPIO_W-1:0]     gpio_in_i,
  output logic [`SPI_GPIO_W-1:0]     gpio_out_o,
  output logic [`SPI_GPIO_W-1:0]     gpio_ddr_o
);

  import spi_regmap_pkg::*;
  import spi_xfer_pkg::*;

  // --------------------------------------------------
  // internal links
  // --------------------------------------------------

  spi_xfer_req_t  xfer_req;
  spi_xfer_rsp_t  xfer_rsp;
  spi_pins_t      pins;
  slave_map_tbl_t map_tbl;
  logic           miso;

  // ctrlport decode and registers
  spi_gpio_regs spi_gpio_regs_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .ctrl_req_i   (ctrl_req_i),
    .ctrl_resp_o  (ctrl_resp_o),
    .xfer_req_o   (xfer_req),
    .xfer_rsp_i   (xfer_rsp),
    .map_tbl_o    (map_tbl)
  );

  // shift engine
  spi_xfer_engine spi_xfer_engine_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .xfer_req_i   (xfer_req),
    .xfer_rsp_o   (xfer_rsp),
    .pins_o       (pins),
    .miso_i       (miso)
  );

  // gpio line mapping
  spi_gpio_pinmux spi_gpio_pinmux_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .map_tbl_i    (map_tbl),
    .pins_i       (pins),
    .miso_o       (miso),
    .gpio_in_i    (gpio_in_i),
    .gpio_out_o   (gpio_out_o),
    .gpio_ddr_o   (gpio_ddr_o)
  );

endmodule

// File: rtl/spi_regmap_pkg.sv
`include "spi_gpio_settings.svh"

package spi_regmap_pkg;

  // ctrlport words
  typedef logic [`SPI_ADDR_W-1:0] ctrl_addr_t;
  typedef logic [`SPI_DATA_W-1:0] ctrl_data_t;

  // response codes, same encoding as the ctrlport spec
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    CMDERR = 2'b01
  } ctrl_sts_t;

  typedef struct packed {
    logic       wr;
    logic       rd;
    ctrl_addr_t addr;
    ctrl_data_t data;
  } ctrl_req_t;

  typedef struct packed {
    logic       ack;
    ctrl_sts_t  status;
    ctrl_data_t data;
  } ctrl_resp_t;

  // register fields
  typedef logic [`SPI_IDX_W-1:0] gpio_idx_t;
  typedef logic [`SPI_LEN_W-1:0] spi_len_t;
  typedef logic [`SPI_DIV_W-1:0] clk_div_t;
  typedef logic [`SPI_SEL_W-1:0] slave_sel_t;

  // field order matches the setup register, sclk in bits 4:0
  typedef struct packed {
    gpio_idx_t cs;
    gpio_idx_t miso;
    gpio_idx_t mosi;
    gpio_idx_t sclk;
  } slave_map_t;

  typedef slave_map_t [`SPI_NUM_SLAVES-1:0] slave_map_tbl_t;

  // setup register bits 27:0
  typedef struct packed {
    logic       mosi_edge;
    logic       miso_edge;
    spi_len_t   length;
    slave_map_t map;
  } slave_cfg_t;

  // transaction config bits 17:0
  typedef struct packed {
    slave_sel_t slave;
    clk_div_t   divider;
  } xfer_cfg_t;

endpackage

// File: rtl/spi_xfer_engine.sv
`timescale 1ns/1ps
`include "spi_gpio_settings.svh"

module spi_xfer_engine (
  input  logic                        ctrlport_clk,
  input  logic                        ctrlport_rst,
  input  spi_xfer_pkg::spi_xfer_req_t xfer_req_i,
  output spi_xfer_pkg::spi_xfer_rsp_t xfer_rsp_o,
  output spi_xfer_pkg::spi_pins_t     pins_o,
  input  logic                        miso_i
);

  import spi_regmap_pkg::*;
  import spi_xfer_pkg::*;

  // up to 2 x 32 sclk edges
  localparam int EDGE_W = $bits(spi_len_t) + 1;
  localparam int DATA_MSB = $bits(ctrl_data_t) - 1;
  localparam int RX_MSB = $bits(spi_rx_t) - 1;

  engine_state_t     state;
  clk_div_t          div_cnt;
  logic [EDGE_W-1:0] edge_cnt;
  ctrl_data_t        tx_sr;
  spi_rx_t           rx_sr;
  logic              tick;
  logic              edge_now;
  logic              last_edge;
  logic              rising;
  logic              do_sample;
  logic              do_launch;

  // --------------------------------------------------
  // edge timing
  // --------------------------------------------------

  // half period is divider+1 cycles
  assign tick      = (div_cnt == xfer_req_i.divider);
  assign edge_now  = tick && ((state == SETUP) || (state == SHIFT));
  assign last_edge = (edge_cnt == ({xfer_req_i.length, 1'b0} - EDGE_W'(1)));
  // sclk idles low, so the next edge rises when sclk is low
  assign rising    = ~pins_o.sclk;
  assign do_sample = edge_now && (rising == xfer_req_i.miso_edge);
  // first bit already set up with cs, so skip a launch on edge 0
  assign do_launch = edge_now && (rising == xfer_req_i.mosi_edge) && (edge_cnt != '0);

  // --------------------------------------------------
  // state machine and pins
  // --------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state      <= IDLE;
      pins_o     <= '{sclk: 1'b0, mosi: 1'b0, cs_n: '1};
      xfer_rsp_o <= '0;
    end else begin
      xfer_rsp_o.done <= 1'b0;
      case (state)
        IDLE: begin
          if (xfer_req_i.start) begin
            state       <= SETUP;
            pins_o.cs_n <= ~(cs_vec_t'(1) << xfer_req_i.slave);
            pins_o.mosi <= xfer_req_i.data[DATA_MSB];
          end
        end
        SETUP, SHIFT: begin
          if (tick) begin
            pins_o.sclk <= rising;
            if (do_launch) begin
              pins_o.mosi <= tx_sr[DATA_MSB];
            end
            // sclk is back low after the last edge
            state <= last_edge ? FINISH : SHIFT;
          end
        end
        FINISH: begin
          // cs release and done on the same cycle
          if (tick) begin
            state           <= IDLE;
            pins_o.cs_n     <= '1;
            pins_o.mosi     <= 1'b0;
            xfer_rsp_o.done <= 1'b1;
            xfer_rsp_o.rx   <= rx_sr;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // counters and shift registers
  // --------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (state == IDLE) begin
      div_cnt  <= '0;
      edge_cnt <= '0;
      // msb goes out with cs, the rest waits here
      tx_sr    <= xfer_req_i.data << 1;
      rx_sr    <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (edge_now) begin
        edge_cnt <= edge_cnt + 1'b1;
      end
      if (do_launch) begin
        tx_sr <= tx_sr << 1;
      end
      // fills from the lsb, oldest bits fall off the top
      if (do_sample) begin
        rx_sr <= {rx_sr[RX_MSB-1:0], miso_i};
      end
    end
  end

  // one slave selected at a time
  a_one_cs : assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    $onehot0(~pins_o.cs_n));

  // regs holds go until done came back
  a_start_idle : assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    xfer_req_i.start |-> (state == IDLE));

endmodule

// File: rtl/spi_xfer_pkg.sv
`include "spi_gpio_settings.svh"

package spi_xfer_pkg;

  // received word as seen in the status register
  typedef logic [`SPI_RX_W-1:0] spi_rx_t;

  // one chip select per slave, active low
  typedef logic [`SPI_NUM_SLAVES-1:0] cs_vec_t;

  // one transfer, fields valid with start
  typedef struct packed {
    logic                       start;
    spi_regmap_pkg::ctrl_data_t data;
    spi_regmap_pkg::spi_len_t   length;
    logic                       miso_edge;
    logic                       mosi_edge;
    spi_regmap_pkg::slave_sel_t slave;
    spi_regmap_pkg::clk_div_t   divider;
  } spi_xfer_req_t;

  typedef struct packed {
    logic    done;
    spi_rx_t rx;
  } spi_xfer_rsp_t;

  // engine side of the bus, before the gpio mapping
  typedef struct packed {
    logic    sclk;
    logic    mosi;
    cs_vec_t cs_n;
  } spi_pins_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    SHIFT,
    FINISH
  } engine_state_t;

endpackage

// File: test/tb_spi_gpio.sv
`timescale 1ns/1ps
`include "spi_gpio_settings.svh"

module tb_spi_gpio;

  import spi_regmap_pkg::*;

  localparam int ACK_TIMEOUT = 8;
  localparam int READY_POLLS = 400;
  localparam int CS_TIMEOUT  = 20;

  localparam ctrl_addr_t ADDR_SLAVE0 = `SPI_BASE_ADDR + `SPI_OFS_SLAVE0;
  localparam ctrl_addr_t ADDR_CFG    = `SPI_BASE_ADDR + `SPI_OFS_XFER_CFG;
  localparam ctrl_addr_t ADDR_GO     = `SPI_BASE_ADDR + `SPI_OFS_GO;
  localparam ctrl_addr_t ADDR_STATUS = `SPI_BASE_ADDR + `SPI_OFS_STATUS;
  localparam ctrl_addr_t ADDR_INFO   = `SPI_BASE_ADDR + `SPI_OFS_INFO;

  // cs of slave s sits on line 4s+2
  localparam logic [`SPI_GPIO_W-1:0] CS_MASK = 32'h0000_4444;

  // one register access and its expected response
  typedef struct packed {
    logic       wr;
    ctrl_addr_t addr;
    ctrl_data_t data;
    ctrl_sts_t  sts;
    ctrl_data_t exp;
    logic       ack;
  } reg_step_t;

  // one loopback transfer
  typedef struct packed {
    slave_sel_t slave;
    spi_len_t   length;
    logic       miso_edge;
    logic       mosi_edge;
    clk_div_t   divider;
  } xfer_step_t;

  logic                   ctrlport_clk;
  logic                   ctrlport_rst;
  ctrl_req_t              ctrl_req;
  ctrl_resp_t             ctrl_resp;
  logic [`SPI_GPIO_W-1:0] gpio_in;
  logic [`SPI_GPIO_W-1:0] gpio_out;
  logic [`SPI_GPIO_W-1:0] gpio_ddr;

  reg_step_t  reg_tbl [10];
  xfer_step_t xfer_tbl [8];
  ctrl_data_t lcg_state;
  int         errors;
  int         tests;

  // a slave with miso on its mosi line hears itself through the loopback
  assign gpio_in = gpio_out;

  spi_gpio_top spi_gpio_top_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .ctrl_req_i   (ctrl_req),
    .ctrl_resp_o  (ctrl_resp),
    .gpio_in_i    (gpio_in),
    .gpio_out_o   (gpio_out),
    .gpio_ddr_o   (gpio_ddr)
  );

  initial begin
    ctrlport_clk = 1'b0;
    forever #20 ctrlport_clk = ~ctrlport_clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic ctrl_data_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // slave s puts sclk on line 4s, mosi and miso on 4s+1 and cs on 4s+2
  function automatic ctrl_data_t make_setup(input slave_sel_t s, input spi_len_t len,
                                            input logic miso_edge, input logic mosi_edge);
    gpio_idx_t base;
    base = gpio_idx_t'(4 * int'(s));
    return {4'b0, mosi_edge, miso_edge, len, base + 5'd2, base + 5'd1, base + 5'd1, base};
  endfunction

  // ready in bit 24 with the top len payload bits right-aligned below it
  function automatic ctrl_data_t expect_status(input ctrl_data_t payload, input spi_len_t len);
    ctrl_data_t top;
    int         shift;
    shift = 32 - int'(len);
    top   = payload >> shift;
    return {8'h01, top[23:0]};
  endfunction

  task automatic check_sts(input ctrl_sts_t got, input ctrl_sts_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @ %0t: %s status %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input ctrl_data_t got, input ctrl_data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @ %0t: %s data 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_gpio(input logic [`SPI_GPIO_W-1:0] got,
                            input logic [`SPI_GPIO_W-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @ %0t: %s 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "mismatch");
  endtask

  // one-cycle request on the falling edge and a bounded wait for the ack
  task automatic bus_access(input logic wr, input ctrl_addr_t addr, input ctrl_data_t data,
                            output logic got_ack, output ctrl_resp_t resp);
    int waited;
    got_ack = 1'b0;
    resp    = '0;
    waited  = 0;
    @(negedge ctrlport_clk);
    ctrl_req.wr   = wr;
    ctrl_req.rd   = !wr;
    ctrl_req.addr = addr;
    ctrl_req.data = data;
    @(negedge ctrlport_clk);
    ctrl_req = '0;
    while (!got_ack && waited < ACK_TIMEOUT) begin
      if (ctrl_resp.ack) begin
        got_ack = 1'b1;
        resp    = ctrl_resp;
      end else begin
        @(negedge ctrlport_clk);
        waited++;
      end
    end
  endtask

  task automatic do_write(input ctrl_addr_t addr, input ctrl_data_t data, input string what);
    logic       got_ack;
    ctrl_resp_t resp;
    bus_access(1'b1, addr, data, got_ack, resp);
    if (!got_ack) begin
      errors++;
      $display("no ack for write at 0x%05h", addr);
    end else begin
      check_sts(resp.status, OKAY, what);
      check_data(resp.data, '0, what);
    end
  endtask

  // poll status until the ready bit shows up
  task automatic wait_ready(output ctrl_data_t status);
    logic       got_ack;
    logic       seen;
    ctrl_resp_t resp;
    int         polls;
    status = '0;
    seen   = 1'b0;
    polls  = 0;
    while (!seen && polls < READY_POLLS) begin
      bus_access(1'b0, ADDR_STATUS, '0, got_ack, resp);
      if (!got_ack) begin
        errors++;
        $display("no ack for read at 0x%05h", ADDR_STATUS);
        polls = READY_POLLS;
      end else if (resp.data[24]) begin
        seen   = 1'b1;
        status = resp.data;
      end
      polls++;
    end
    if (!seen) begin
      errors++;
      $display("ready never set");
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    logic       got_ack;
    ctrl_resp_t resp;
    ctrl_data_t status;
    ctrl_data_t payload;
    ctrl_data_t second;
    xfer_step_t xs;
    int         err0;
    int         cs_line;
    int         waited;

    ctrl_req     = '0;
    ctrlport_rst = 1'b1;
    errors       = 0;
    tests        = 0;
    lcg_state    = 32'd94;

    // reset values followed by out-of-map, read-only and gap accesses
    reg_tbl[0] = '{1'b0, ADDR_STATUS, 32'h0, OKAY, 32'h0100_0000, 1'b1};
    reg_tbl[1] = '{1'b0, ADDR_INFO, 32'h0, OKAY, 32'h0000_0004, 1'b1};
    reg_tbl[2] = '{1'b1, ADDR_CFG, 32'h0002_0003, OKAY, 32'h0, 1'b1};
    reg_tbl[3] = '{1'b0, ADDR_CFG, 32'h0, OKAY, 32'h0002_0003, 1'b1};
    reg_tbl[4] = '{1'b0, ADDR_SLAVE0 + 20'h4, 32'h0, CMDERR, 32'h0, 1'b1};
    reg_tbl[5] = '{1'b0, ADDR_GO, 32'h0, CMDERR, 32'h0, 1'b1};
    reg_tbl[6] = '{1'b1, ADDR_STATUS, 32'h1234, CMDERR, 32'h0, 1'b1};
    reg_tbl[7] = '{1'b1, ADDR_INFO, 32'h1234, CMDERR, 32'h0, 1'b1};
    reg_tbl[8] = '{1'b1, 20'h00005, 32'h1234, CMDERR, 32'h0, 1'b1};
    reg_tbl[9] = '{1'b0, 20'h00040, 32'h0, OKAY, 32'h0, 1'b0};

    // both edge pairs with opposite launch and sample
    xfer_tbl[0] = '{2'd0, 6'd8, 1'b1, 1'b0, 16'd1};
    xfer_tbl[1] = '{2'd1, 6'd16, 1'b0, 1'b1, 16'd2};
    xfer_tbl[2] = '{2'd2, 6'd24, 1'b1, 1'b0, 16'd1};
    xfer_tbl[3] = '{2'd3, 6'd32, 1'b0, 1'b1, 16'd1};
    xfer_tbl[4] = '{2'd0, 6'd1, 1'b1, 1'b0, 16'd3};
    xfer_tbl[5] = '{2'd1, 6'd5, 1'b0, 1'b1, 16'd1};
    xfer_tbl[6] = '{2'd2, 6'd31, 1'b0, 1'b1, 16'd2};
    xfer_tbl[7] = '{2'd3, 6'd12, 1'b1, 1'b0, 16'd1};

    repeat (16) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;

    // direction register reloads from the reset mapping once reset is gone
    err0 = errors;
    repeat (2) @(negedge ctrlport_clk);
    check_gpio(gpio_ddr, '0, "ddr after reset");
    end_test("reset ddr", err0);

    for (int i = 0; i < 10; i++) begin
      err0 = errors;
      bus_access(reg_tbl[i].wr, reg_tbl[i].addr, reg_tbl[i].data, got_ack, resp);
      if (reg_tbl[i].ack && !got_ack) begin
        errors++;
        $display("no ack for %s at 0x%05h", reg_tbl[i].wr ? "write" : "read", reg_tbl[i].addr);
      end else if (!reg_tbl[i].ack && got_ack) begin
        errors++;
        $display("FAILED @ %0t: unexpected ack at 0x%05h", $time, reg_tbl[i].addr);
      end else if (got_ack) begin
        check_sts(resp.status, reg_tbl[i].sts, "register access");
        check_data(resp.data, reg_tbl[i].exp, "register access");
      end
      end_test($sformatf("register step %0d", i), err0);
    end

    // direction follows the mapped lines one cycle behind the write
    err0 = errors;
    do_write(ADDR_SLAVE0, make_setup(2'd0, 6'd8, 1'b1, 1'b0), "slave 0 setup");
    do_write(ADDR_SLAVE0 + 20'h4, make_setup(2'd1, 6'd8, 1'b1, 1'b0), "slave 1 setup");
    repeat (2) @(negedge ctrlport_clk);
    check_gpio(gpio_ddr, 32'h0000_0077, "ddr with two slaves");
    do_write(ADDR_SLAVE0 + 20'h8, make_setup(2'd2, 6'd8, 1'b1, 1'b0), "slave 2 setup");
    do_write(ADDR_SLAVE0 + 20'hC, make_setup(2'd3, 6'd8, 1'b1, 1'b0), "slave 3 setup");
    repeat (2) @(negedge ctrlport_clk);
    check_gpio(gpio_ddr, 32'h0000_7777, "ddr with four slaves");
    end_test("slave setup ddr", err0);

    // --------------------------------------------------
    // loopback transfers
    // --------------------------------------------------

    for (int i = 0; i < 8; i++) begin
      err0    = errors;
      xs      = xfer_tbl[i];
      payload = lcg_next();
      do_write(ADDR_SLAVE0 + ctrl_addr_t'(4 * int'(xs.slave)),
               make_setup(xs.slave, xs.length, xs.miso_edge, xs.mosi_edge), "setup");
      do_write(ADDR_CFG, {14'b0, xs.slave, xs.divider}, "transfer config");
      do_write(ADDR_GO, payload, "go");
      wait_ready(status);
      check_data(status, expect_status(payload, xs.length), "received bits");
      end_test($sformatf("transfer slave %0d len %0d edges %0d/%0d", xs.slave, xs.length,
                         xs.miso_edge, xs.mosi_edge), err0);
    end

    // a second go during a busy transfer on slave 2 gets dropped
    err0    = errors;
    payload = lcg_next();
    second  = lcg_next();
    cs_line = 4 * 2 + 2;
    waited  = 0;
    do_write(ADDR_SLAVE0 + 20'h8, make_setup(2'd2, 6'd32, 1'b1, 1'b0), "setup");
    do_write(ADDR_CFG, {14'b0, 2'd2, 16'd3}, "transfer config");
    do_write(ADDR_GO, payload, "first go");
    while (gpio_out[cs_line] !== 1'b0 && waited < CS_TIMEOUT) begin
      @(negedge ctrlport_clk);
      waited++;
    end
    if (waited >= CS_TIMEOUT) begin
      errors++;
      $display("chip select of slave 2 never went low");
    end
    check_gpio(gpio_out & CS_MASK, CS_MASK & ~(32'h1 << cs_line), "cs lines while busy");
    do_write(ADDR_GO, second, "second go");
    wait_ready(status);
    check_data(status, expect_status(payload, 6'd32), "status after busy go");
    // nothing started behind the first transfer
    bus_access(1'b0, ADDR_STATUS, '0, got_ack, resp);
    if (!got_ack) begin
      errors++;
      $display("no ack for read at 0x%05h", ADDR_STATUS);
    end else begin
      check_data(resp.data, expect_status(payload, 6'd32), "status after done");
    end
    check_gpio(gpio_out & CS_MASK, CS_MASK, "cs lines when idle");
    end_test("go while busy", err0);

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
